/* all.f */
design/snd_pkg.sv
design/snd_decoder.sv
design/snd_ram.sv
design/pcm_voice.sv
design/pcm_player.sv
design/snd_top.sv
bench/snd_tb.sv

/* bench/snd_tb.sv */
/*
  testbench for the sound board top, CPU bus and all ROMs are modeled here
  inputs change on the falling edge, assertions sample on the rising edge
  runs the SCONTRA map first, then the ALIENS map
*/
`timescale 1ns/1ps

module snd_tb;
    import snd_pkg::*;

    logic               clk;
    logic               rst = 1'b1;
    logic               cen = 1'b0;
    board_e             cfg = SCONTRA;
    cpu_bus_t           cpu = '0;
    logic        [ 7:0] snd_latch = 8'd0;
    logic               rom_ok = 1'b0;
    logic        [ 7:0] cpu_din, rom_data, pcma_data, pcmb_data;
    logic        [14:0] rom_addr;
    logic               rom_cs, pcma_ok, pcmb_ok;
    pcm_rom_t           pcma, pcmb;
    logic signed [11:0] pcm;

    logic [31:0] seed     = 32'hc671_b555;    // stimulus
    logic [31:0] lat_seed = 32'hc671_b555;    // ROM latencies, own stream
    logic [ 1:0] rom_wait = 2'd0;
    logic [ 1:0] cen_cnt  = 2'd0;
    logic        exp_on   = 1'b0;             // a read is being checked
    logic [ 7:0] exp_din  = 8'd0;
    logic        pcm_wr = 1'b0, bank_wr = 1'b0, ct_wr = 1'b0;   // tags for the model

    // sample ROM side, index 0 is voice A
    pcm_rom_t    rq [2];
    logic [ 7:0] pd [2];
    logic        rok      [2] = '{1'b0, 1'b0};
    logic [ 1:0] pcm_wait [2] = '{2'd0, 2'd0};
    logic [16:0] end_at   [2] = '{17'd0, 17'd0};   // marker position

    // reference model
    logic [16:0] start_m  [2] = '{17'd0, 17'd0};
    logic [16:0] exp_addr [2] = '{17'd0, 17'd0};
    logic        loop_m   [2] = '{1'b0, 1'b0};
    logic        play_m   [2] = '{1'b0, 1'b0};
    logic [ 1:0] exp_msb  [2] = '{2'd0, 2'd0};
    int          exp_smp  [2] = '{0, 0};
    int          markers  [2] = '{0, 0};           // end markers fetched so far
    logic [ 3:0] bank_m = 4'd0;
    logic [ 1:0] ct_m   = 2'd0;
    logic [ 7:0] vol_m  = 8'd0;
    logic        aliens;

    assign aliens    = cfg == ALIENS || cfg == CRIMFGHT;
    assign rq[0]     = pcma;
    assign rq[1]     = pcmb;
    assign pcma_ok   = rok[0];
    assign pcmb_ok   = rok[1];
    assign rom_data  = prog_byte(rom_addr);
    assign pcma_data = smp_byte(pcma.addr, end_at[0]);
    assign pcmb_data = smp_byte(pcmb.addr, end_at[1]);
    assign pd[0]     = pcma_data;
    assign pd[1]     = pcmb_data;

    snd_top u_dut(
        .clk ( clk ), .rst ( rst ), .cfg ( cfg ), .cen ( cen ), .cpu ( cpu ),
        .cpu_din ( cpu_din ), .snd_latch ( snd_latch ), .rom_addr ( rom_addr ),
        .rom_cs ( rom_cs ), .rom_data ( rom_data ), .rom_ok ( rom_ok ),
        .pcma ( pcma ), .pcma_data ( pcma_data ), .pcma_ok ( pcma_ok ),
        .pcmb ( pcmb ), .pcmb_data ( pcmb_data ), .pcmb_ok ( pcmb_ok ), .pcm ( pcm )
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] rand16();
        seed = lcg_step(seed);
        return seed[31:16];     // upper half, low bits cycle too fast
    endfunction

    function automatic logic [7:0] prog_byte(input logic [14:0] a);
        return a[7:0] ^ {1'b0, a[14:8]} ^ 8'h5a;
    endfunction

    function automatic logic [7:0] smp_byte(input logic [18:0] a, input logic [16:0] e);
        if (a[16:0] == e)
            return {1'b1, a[6:0]};
        return {1'b0, a[6:0] ^ a[13:7] ^ {2'b00, a[18:14]}};
    endfunction

    // volume nibble as the voice sees it, crossed on scontra style boards
    function automatic int gain(input int v);
        logic [7:0] e;
        e = aliens ? vol_m : {vol_m[3:0], vol_m[7:4]};
        return v == 0 ? int'(e[3:0]) : int'(e[7:4]);
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ROM latencies and the cen strobe, all on the falling edge
    always @(negedge clk) begin
        if (!rom_cs) begin
            lat_seed = lcg_step(lat_seed);
            rom_ok   <= 1'b0;
            rom_wait <= lat_seed[17:16];
        end else if (!rom_ok) begin
            if (rom_wait == 2'd0)
                rom_ok <= 1'b1;
            else
                rom_wait <= rom_wait - 2'd1;
        end
        for (int v = 0; v < 2; v++) begin
            if (!rq[v].cs) begin
                lat_seed = lcg_step(lat_seed);
                rok[v]      <= 1'b0;
                pcm_wait[v] <= lat_seed[17:16];
            end else if (!rok[v]) begin
                if (pcm_wait[v] == 2'd0)
                    rok[v] <= 1'b1;
                else
                    pcm_wait[v] <= pcm_wait[v] - 2'd1;
            end
        end
        cen_cnt <= cen_cnt + 2'd1;
        cen     <= cen_cnt == 2'd0;     // one pulse every 4 cycles
    end

    // model of banking, PCM registers and voice fetches
    always @(posedge clk) begin
        if (bank_wr)
            bank_m <= cpu.dout[3:0];
        if (ct_wr)
            ct_m <= cpu.dout[7:6];
        if (pcm_wr) begin
            case (cpu.addr[3:0])
                4'd0: start_m[0][7:0]  <= cpu.dout;
                4'd1: start_m[0][15:8] <= cpu.dout;
                4'd2: begin
                    start_m[0][16] <= cpu.dout[0];
                    loop_m[0]      <= cpu.dout[1];
                end
                4'd4: start_m[1][7:0]  <= cpu.dout;
                4'd5: start_m[1][15:8] <= cpu.dout;
                4'd6: begin
                    start_m[1][16] <= cpu.dout[0];
                    loop_m[1]      <= cpu.dout[1];
                end
                4'd12: vol_m <= cpu.dout;
                default: ;
            endcase
        end
        exp_msb[0] <= aliens ? {1'b0, ct_m[1]} : bank_m[1:0];
        exp_msb[1] <= aliens ? {1'b0, ct_m[0]} : bank_m[3:2];
        for (int v = 0; v < 2; v++) begin
            if (pcm_wr && cpu.addr[3:0] == (v == 0 ? 4'd3 : 4'd7)) begin
                play_m[v]   <= 1'b1;    // key-on wins over a fetch
                exp_addr[v] <= start_m[v];
            end else if (rq[v].cs && rok[v]) begin
                if (pd[v][PCM_END]) begin
                    play_m[v]  <= loop_m[v];
                    markers[v] <= markers[v] + 1;
                    if (loop_m[v])
                        exp_addr[v] <= start_m[v];
                end else begin
                    exp_addr[v] <= exp_addr[v] + 17'd1;
                    exp_smp[v]  <= (int'(pd[v][6:0]) - PCM_BIAS) * gain(v);
                end
            end
        end
    end

    // every read, rom data counts once ok is up
    assert property (@(posedge clk) disable iff (rst)
        exp_on && (!rom_cs || rom_ok) |-> cpu_din == exp_din)
        else stop_run($sformatf("FAIL %0t: read at %h gave %h, expected %h",
                                $time, cpu.addr, cpu_din, exp_din));

    // mix checked two idle cycles after the last fetch
    assert property (@(posedge clk) disable iff (rst)
        !pcma.cs && !pcmb.cs && $past(!pcma.cs && !pcmb.cs)
        |-> int'(pcm) == exp_smp[0] + exp_smp[1])
        else stop_run($sformatf("FAIL %0t: pcm is %0d, expected %0d",
                                $time, pcm, exp_smp[0] + exp_smp[1]));

    for (genvar v = 0; v < 2; v++) begin : g_voice_chk
        assert property (@(posedge clk) disable iff (rst)
            rq[v].cs |-> rq[v].addr[16:0] == exp_addr[v])
            else stop_run($sformatf("FAIL %0t: voice %0d fetched %h, expected %h",
                                    $time, v, rq[v].addr[16:0], exp_addr[v]));
        assert property (@(posedge clk) disable iff (rst)
            rq[v].cs |-> rq[v].addr[18:17] == exp_msb[v])
            else stop_run($sformatf("FAIL %0t: voice %0d bank bits %b, expected %b",
                                    $time, v, rq[v].addr[18:17], exp_msb[v]));
        assert property (@(posedge clk) disable iff (rst)
            !play_m[v] |-> !rq[v].cs)
            else stop_run($sformatf("FAIL %0t: voice %0d fetches while stopped",
                                    $time, v));
    end

    task automatic bus_read(input logic [15:0] a, input logic [7:0] exp_d);
        int n;
        @(negedge clk);
        cpu     <= {a, 8'h00, 1'b1, 1'b1, 1'b0};
        exp_din <= exp_d;
        exp_on  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 40)
                stop_run("timed out waiting for rom_ok on a program ROM read");
        end while (rom_cs && !rom_ok);
        @(negedge clk);
        cpu    <= '0;
        exp_on <= 1'b0;
    endtask

    // tag is {ct, bank, pcm}, wr held for exactly one cycle
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d, input logic [2:0] tag);
        @(negedge clk);
        cpu                      <= {a, d, 1'b1, 1'b0, 1'b1};
        {ct_wr, bank_wr, pcm_wr} <= tag;
        @(negedge clk);
        cpu                      <= '0;
        {ct_wr, bank_wr, pcm_wr} <= 3'b000;
    endtask

    task automatic pcm_reg(input logic [3:0] r, input logic [7:0] d);
        bus_write((aliens ? 16'he000 : 16'hb000) | {12'd0, r}, d, 3'b001);
    endtask

    // scontra bank register, or the FM CT pins on aliens
    task automatic set_bank(input logic [7:0] d);
        logic [15:0] fm;
        fm = aliens ? 16'ha000 : 16'hc000;
        if (aliens) begin
            bus_write(fm, 8'h10, 3'b000);           // other register, no CT change
            bus_write(fm | 16'd1, ~d, 3'b000);
            bus_write(fm, FM_CT_REG, 3'b000);
            bus_write(fm | 16'd1, d, 3'b100);
        end else begin
            bus_write(16'hf000, d, 3'b010);
        end
    endtask

    // random start, marker a few bytes in, then key-on
    task automatic key_voice(input int v, input logic lp);
        logic [15:0] r;
        logic [16:0] st;
        logic [ 3:0] base;
        r         = rand16();
        st        = {r[0], rand16()};
        base      = v == 0 ? 4'd0 : 4'd4;
        end_at[v] = st + {14'd0, r[3:1]} + 17'd2;   // 2 to 9 samples before it
        pcm_reg(base, st[7:0]);
        pcm_reg(base + 4'd1, st[15:8]);
        pcm_reg(base + 4'd2, {6'd0, lp, st[16]});
        pcm_reg(base + 4'd3, 8'd0);
    endtask

    task automatic wait_wraps(input int w);
        int m0, m1, n;
        m0 = markers[0];
        m1 = markers[1];
        n  = 0;
        while (markers[0] < m0 + w || markers[1] < m1 + w) begin
            @(negedge clk);
            n++;
            if (n > 600)
                stop_run("timed out waiting for the looping voices to wrap");
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (play_m[0] || play_m[1] || pcma.cs || pcmb.cs) begin
            @(negedge clk);
            n++;
            if (n > 400)
                stop_run("timed out waiting for both PCM voices to stop");
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic run_board(input board_e b);
        logic [15:0] r;
        logic [15:0] a;
        logic [15:0] ram_a [8];
        logic [ 7:0] ram_d [8];
        @(negedge clk);
        cfg <= b;
        repeat (4) @(negedge clk);
        repeat (8) begin
            r = rand16();
            bus_read({1'b0, r[14:0]}, prog_byte(r[14:0]));
        end
        // one write per 256-byte page, aliens goes through a mirror
        for (int k = 0; k < 8; k++) begin
            r        = rand16();
            ram_a[k] = (aliens ? 16'h9800 : 16'h8000) | {5'd0, k[2:0], r[7:0]};
            ram_d[k] = r[15:8];
            bus_write(ram_a[k], ram_d[k], 3'b000);
        end
        for (int k = 0; k < 8; k++)
            bus_read(ram_a[k], ram_d[k]);
        // sound latch
        r = rand16();
        snd_latch <= r[7:0];
        a = aliens ? {3'b110, r[15:3]} : {4'b1010, r[15:4]};
        bus_read(a, r[7:0]);
        // FM, PCM, bank and unused space all read as open bus
        for (int k = 0; k < 4; k++) begin
            r = rand16();
            a = aliens ? {1'b1, r[12], 1'b1, r[12:0]} : {2'b11, r[13:0]};
            bus_read(a, 8'hff);
        end
        // one-shot playback, nibbles always differ
        r = rand16();
        pcm_reg(4'd12, {r[7:4], ~r[7:4]});
        key_voice(0, 1'b0);
        key_voice(1, 1'b0);
        wait_idle();
        // looping playback, banking changes while both voices fetch
        key_voice(0, 1'b1);
        key_voice(1, 1'b1);
        repeat (3) begin
            r = rand16();
            set_bank(r[7:0]);
        end
        wait_wraps(2);
        pcm_reg(4'd2, {6'd0, 1'b0, start_m[0][16]});
        pcm_reg(4'd6, {6'd0, 1'b0, start_m[1][16]});
        wait_idle();
    endtask

    initial begin
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        run_board(SCONTRA);
        run_board(ALIENS);
        $display("Regression passed");
        $finish;
    end

endmodule

/* design/pcm_player.sv */
/*
  two-voice PCM player, register file at A[3:0]
  regs 0-2 and 4-6 hold start and loop, a write to 3 or 7 keys the voice on
  reg 12 holds the volumes as {B, A}, swap_gains exchanges the nibbles
  write start and loop before the key-on write
*/
`timescale 1ns/1ps

module pcm_player(
    input                            clk,
    input                            rst,
    input                            cen,
    input                            we,
    input        [3:0]               addr,
    input        [7:0]               din,
    input                            swap_gains,
    input        [1:0]               msb_a,
    input        [1:0]               msb_b,
    input        [7:0]               pcma_data,
    input                            pcma_ok,
    input        [7:0]               pcmb_data,
    input                            pcmb_ok,
    output snd_pkg::pcm_rom_t        pcma,
    output snd_pkg::pcm_rom_t        pcmb,
    output logic signed [11:0]       pcm
);
    logic        [16:0] start_a, start_b;
    logic               loop_a, loop_b;
    logic        [ 7:0] vol;
    logic        [ 7:0] vol_eff;
    logic               key_a, key_b;
    logic signed [10:0] sample_a, sample_b;

    // key-on strobes straight from the write
    assign key_a   = we && addr == 4'd3;
    assign key_b   = we && addr == 4'd7;
    assign vol_eff = swap_gains ? {vol[3:0], vol[7:4]} : vol;

    // start addresses
    always_ff @(posedge clk) begin
        if (we) begin
            case (addr)
                4'd0: start_a[ 7:0] <= din;
                4'd1: start_a[15:8] <= din;
                4'd2: start_a[16]   <= din[0];
                4'd4: start_b[ 7:0] <= din;
                4'd5: start_b[15:8] <= din;
                4'd6: start_b[16]   <= din[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loop_a <= 1'b0;
            loop_b <= 1'b0;
            vol    <= 8'd0;
        end else if (we) begin
            if (addr == 4'd2)
                loop_a <= din[1];
            if (addr == 4'd6)
                loop_b <= din[1];
            if (addr == 4'd12)
                vol <= din;     // {B, A}
        end
    end

    pcm_voice u_voice_a(
        .clk      ( clk          ),
        .rst      ( rst          ),
        .cen      ( cen          ),
        .key_on   ( key_a        ),
        .start    ( start_a      ),
        .loop     ( loop_a       ),
        .msb      ( msb_a        ),
        .vol      ( vol_eff[3:0] ),
        .rom_data ( pcma_data    ),
        .rom_ok   ( pcma_ok      ),
        .rom      ( pcma         ),
        .sample   ( sample_a     )
    );

    pcm_voice u_voice_b(
        .clk      ( clk          ),
        .rst      ( rst          ),
        .cen      ( cen          ),
        .key_on   ( key_b        ),
        .start    ( start_b      ),
        .loop     ( loop_b       ),
        .msb      ( msb_b        ),
        .vol      ( vol_eff[7:4] ),
        .rom_data ( pcmb_data    ),
        .rom_ok   ( pcmb_ok      ),
        .rom      ( pcmb         ),
        .sample   ( sample_b     )
    );

    // mix, one extra bit of headroom
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pcm <= 12'sd0;
        else
            pcm <= {sample_a[10], sample_a} + {sample_b[10], sample_b};
    end

endmodule

/* design/pcm_voice.sv */
/*
  one PCM voice, 8-bit bytes from a sample ROM with variable latency
  bit 7 of a byte is the end marker, it never reaches the output
  key_on restarts from start at any time and drops a fetch in flight
  cen pulses that arrive during a fetch are skipped
*/
`timescale 1ns/1ps

module pcm_voice(
    input                            clk,
    input                            rst,
    input                            cen,
    input                            key_on,
    input        [16:0]              start,
    input                            loop,
    input        [ 1:0]              msb,
    input        [ 3:0]              vol,
    input        [ 7:0]              rom_data,
    input                            rom_ok,
    output snd_pkg::pcm_rom_t        rom,
    output logic signed [10:0]       sample
);
    import snd_pkg::*;

    logic               playing;
    logic               cs;         // fetch in flight
    logic        [16:0] addr;
    logic signed [ 7:0] centered;   // -64..63
    logic signed [12:0] scaled;

    // byte to signed level, then volume, max 63*15 fits 11 bits
    always_comb begin
        centered = 8'($signed({1'b0, rom_data[6:0]}) - PCM_BIAS);
        scaled   = centered * $signed({1'b0, vol});
    end

    assign rom.addr = {msb, addr};  // bank bits come from the decoder
    assign rom.cs   = cs;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            playing <= 1'b0;
            cs      <= 1'b0;
            addr    <= 17'd0;
        end else if (key_on) begin
            playing <= 1'b1;
            cs      <= 1'b0;
            addr    <= start;
        end else if (cs) begin
            if (rom_ok) begin
                cs <= 1'b0;     // low from the next cycle on
                if (rom_data[PCM_END]) begin
                    playing <= loop;
                    if (loop)
                        addr <= start;
                end else begin
                    addr <= addr + 17'd1;
                end
            end
        end else if (cen && playing) begin
            cs <= 1'b1;
        end
    end

    // output level, held across end markers and stops
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sample <= 11'sd0;
        else if (!key_on && cs && rom_ok && !rom_data[PCM_END])
            sample <= scaled[10:0];
    end

endmodule

/* design/snd_decoder.sv */
/*
  memory map, read mux and sample banking for the sound board
  chip selects are levels, a write lands on every edge with wr high
  FM reads give 8'hff, only the CT pins of the FM chip are kept
*/
`timescale 1ns/1ps

module snd_decoder(
    input                      clk,
    input                      rst,
    input  snd_pkg::board_e    cfg,
    input  snd_pkg::cpu_bus_t  cpu,
    input        [ 7:0]        rom_data,
    input                      rom_ok,
    input        [ 7:0]        ram_dout,
    input        [ 7:0]        snd_latch,
    output logic [ 7:0]        cpu_din,
    output logic               rom_cs,
    output       [14:0]        rom_addr,
    output logic               ram_we,
    output logic               pcm_we,
    output logic [ 1:0]        pcm_msb_a,
    output logic [ 1:0]        pcm_msb_b,
    output logic               swap_gains
);
    import snd_pkg::*;

    logic       mem_upper;
    logic       ram_cs, fm_cs, latch_cs, dac_cs, bank_cs;
    logic [3:0] pcm_bank;   // scontra/thunderx bank register
    logic [7:0] fm_reg;     // latched FM register number
    logic [1:0] ct;         // CT2, CT1

    assign rom_addr = cpu.addr[14:0];

    // chip selects
    always_comb begin
        rom_cs    = cpu.mreq && !cpu.addr[15] && cpu.rd;
        mem_upper = cpu.mreq && cpu.addr[15];
        if (is_aliens_map(cfg)) begin
            ram_cs   = mem_upper && cpu.addr[14:13] == 2'd0;   // 8/9xxx
            fm_cs    = mem_upper && cpu.addr[14:13] == 2'd1;   // A/Bxxx
            latch_cs = mem_upper && cpu.addr[14:13] == 2'd2;   // C/Dxxx
            dac_cs   = mem_upper && cpu.addr[14:13] == 2'd3;   // E/Fxxx
            bank_cs  = 1'b0;                                   // banked by CT
        end else begin
            ram_cs   = mem_upper && cpu.addr[14:12] == 3'd0;   // 8xxx
            latch_cs = mem_upper && cpu.addr[14:12] == 3'd2;   // Axxx
            dac_cs   = mem_upper && cpu.addr[14:12] == 3'd3;   // Bxxx
            fm_cs    = mem_upper && cpu.addr[14:12] == 3'd4;   // Cxxx
            bank_cs  = mem_upper && cpu.addr[14:12] == 3'd7;   // Fxxx
        end
        ram_we = ram_cs && cpu.wr;
        pcm_we = dac_cs && cpu.wr;
    end

    // read data, rom first
    always_comb begin
        if (rom_cs)
            cpu_din = rom_ok ? rom_data : 8'hff;   // CPU waits for ok anyway
        else if (ram_cs)
            cpu_din = ram_dout;
        else if (latch_cs)
            cpu_din = snd_latch;
        else
            cpu_din = 8'hff;    // FM status and open bus
    end

    // bank register plus the FM control port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcm_bank <= 4'd0;
            fm_reg   <= 8'd0;
            ct       <= 2'd0;
        end else begin
            if (bank_cs && cpu.wr)
                pcm_bank <= cpu.dout[3:0];
            if (fm_cs && cpu.wr) begin
                if (!cpu.addr[0])
                    fm_reg <= cpu.dout;             // address phase
                else if (fm_reg == FM_CT_REG)
                    ct <= cpu.dout[7:6];            // data phase, CT pins only
            end
        end
    end

    // upper sample-ROM bits, one cycle behind the source
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcm_msb_a  <= 2'd0;
            pcm_msb_b  <= 2'd0;
            swap_gains <= 1'b0;
        end else if (is_aliens_map(cfg)) begin
            pcm_msb_a  <= {1'b0, ct[1]};
            pcm_msb_b  <= {1'b0, ct[0]};
            swap_gains <= 1'b0;
        end else begin
            pcm_msb_a  <= pcm_bank[1:0];
            pcm_msb_b  <= pcm_bank[3:2];
            swap_gains <= 1'b1;     // gain nibbles wired crossed on these boards
        end
    end

endmodule

/* design/snd_pkg.sv */
/*
  shared types and constants for the sound board
  board_e picks both the memory map and the sample banking scheme
  cpu bus strobes are active high levels held by the CPU side
*/
package snd_pkg;

    // board variants, two map families
    typedef enum logic [1:0] {
        ALIENS   = 2'd0,
        CRIMFGHT = 2'd1,
        SCONTRA  = 2'd2,
        THUNDERX = 2'd3
    } board_e;

    // sound CPU bus as seen by the board
    typedef struct packed {
        logic [15:0] addr;
        logic [ 7:0] dout;     // write data from the CPU
        logic        mreq;
        logic        rd;
        logic        wr;
    } cpu_bus_t;

    // one voice request to its sample ROM
    typedef struct packed {
        logic [18:0] addr;
        logic        cs;       // held until ok
    } pcm_rom_t;

    // work RAM, 2 KB
    localparam int RAM_AW = 11;

    // sample byte layout
    localparam int PCM_END  = 7;    // end marker bit
    localparam int PCM_BIAS = 64;   // zero level of the 7-bit sample

    // FM register that drives the CT pins through bits 7:6
    localparam logic [7:0] FM_CT_REG = 8'h1b;

    // map family test, aliens style boards use A[14:13]
    function automatic logic is_aliens_map(board_e b);
        return b == ALIENS || b == CRIMFGHT;
    endfunction

endpackage

/* design/snd_ram.sv */
/*
  sound CPU work RAM, 2 KB
  contents are undefined after power up, write before reading
  read is asynchronous so the CPU sees data in the same cycle
*/
`timescale 1ns/1ps

module snd_ram(
    input                           clk,
    input                           we,
    input  [snd_pkg::RAM_AW-1:0]    addr,
    input  [7:0]                    din,
    output [7:0]                    dout
);
    import snd_pkg::*;

    logic [7:0] mem [0:(1<<RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= din;   // level write, one edge per cycle of we
    end

    assign dout = mem[addr];

endmodule

/* design/snd_top.sv */
/*
  sound board top, the CPU and the ROMs sit outside
  cfg must stay stable while the CPU runs
  program ROM reads are held by the CPU until rom_ok
*/
`timescale 1ns/1ps

module snd_top(
    input                            clk,
    input                            rst,
    input  snd_pkg::board_e          cfg,
    input                            cen,
    input  snd_pkg::cpu_bus_t        cpu,
    output       [ 7:0]              cpu_din,
    input        [ 7:0]              snd_latch,
    output       [14:0]              rom_addr,
    output                           rom_cs,
    input        [ 7:0]              rom_data,
    input                            rom_ok,
    output snd_pkg::pcm_rom_t        pcma,
    input        [ 7:0]              pcma_data,
    input                            pcma_ok,
    output snd_pkg::pcm_rom_t        pcmb,
    input        [ 7:0]              pcmb_data,
    input                            pcmb_ok,
    output signed [11:0]             pcm
);
    import snd_pkg::*;

    logic [7:0] ram_dout;
    logic       ram_we, pcm_we, swap_gains;
    logic [1:0] pcm_msb_a, pcm_msb_b;

    snd_decoder u_decoder(
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cfg        ( cfg        ),
        .cpu        ( cpu        ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .ram_dout   ( ram_dout   ),
        .snd_latch  ( snd_latch  ),
        .cpu_din    ( cpu_din    ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .ram_we     ( ram_we     ),
        .pcm_we     ( pcm_we     ),
        .pcm_msb_a  ( pcm_msb_a  ),
        .pcm_msb_b  ( pcm_msb_b  ),
        .swap_gains ( swap_gains )
    );

    snd_ram u_ram(
        .clk  ( clk                     ),
        .we   ( ram_we                  ),
        .addr ( cpu.addr[RAM_AW-1:0]    ),
        .din  ( cpu.dout                ),
        .dout ( ram_dout                )
    );

    pcm_player u_pcm(
        .clk        ( clk           ),
        .rst        ( rst           ),
        .cen        ( cen           ),
        .we         ( pcm_we        ),
        .addr       ( cpu.addr[3:0] ),
        .din        ( cpu.dout      ),
        .swap_gains ( swap_gains    ),
        .msb_a      ( pcm_msb_a     ),
        .msb_b      ( pcm_msb_b     ),
        .pcma_data  ( pcma_data     ),
        .pcma_ok    ( pcma_ok       ),
        .pcmb_data  ( pcmb_data     ),
        .pcmb_ok    ( pcmb_ok       ),
        .pcma       ( pcma          ),
        .pcmb       ( pcmb          ),
        .pcm        ( pcm           )
    );

endmodule

/* run.sh */
#!/bin/sh
# compile and run the sound board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module snd_tb -o snd_sim

# the testbench stops with a non-zero status on failure, the log decides
./obj_dir/snd_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
grep -q "Regression passed" sim.log
